// ==== logic/dma_ctrl_pkg.sv ====
// ====================
// dma control package
// widths, register map and descriptor layout
// ====================
`default_nettype none

package dma_ctrl_pkg;

    typedef logic [15:0] ctrl_addr_t;
    typedef logic [31:0] ctrl_word_t;
    typedef logic [63:0] pcie_addr_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [15:0] dma_len_t;
    typedef logic [7:0]  dma_tag_t;

    // 120 bits, pcie address in the top bits
    typedef struct packed {
        pcie_addr_t pcie_addr;
        axi_addr_t  axi_addr;
        dma_len_t   len;
        dma_tag_t   tag;
    } dma_desc_t;

    // absolute offset
    localparam ctrl_addr_t REG_ENABLE = 16'h0000;

    // relative to a channel base
    localparam ctrl_addr_t REG_PCIE_LO  = 16'h0000;
    localparam ctrl_addr_t REG_PCIE_HI  = 16'h0004;
    localparam ctrl_addr_t REG_AXI_ADDR = 16'h0008;
    localparam ctrl_addr_t REG_LEN      = 16'h0010;
    localparam ctrl_addr_t REG_TAG      = 16'h0014;
    localparam ctrl_addr_t REG_STATUS   = 16'h0018;

    // relative to the counter base
    localparam ctrl_addr_t CNT_RQ = 16'h0000;
    localparam ctrl_addr_t CNT_RC = 16'h0004;
    localparam ctrl_addr_t CNT_CQ = 16'h0008;
    localparam ctrl_addr_t CNT_CC = 16'h000C;

    localparam int STATUS_VALID_BIT = 31;

endpackage

`default_nettype wire

// ==== logic/reg_bus_if.sv ====
// ====================
// register bus
// write and read strobes from the AXI-lite slave to its targets
// ====================
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if
    import dma_ctrl_pkg::*;
();

    logic       wr_en;
    ctrl_addr_t wr_addr;
    ctrl_word_t wr_data;
    logic       rd_en;
    ctrl_addr_t rd_addr;

    modport initiator (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_en,
        output rd_addr
    );

    modport target (
        input wr_en,
        input wr_addr,
        input wr_data,
        input rd_en,
        input rd_addr
    );

endinterface

`default_nettype wire

// ==== logic/ctrl_reg_slave.sv ====
// ====================
// control register slave
// AXI-lite handshake, enable bit, read merge and interrupt level
// ====================
`timescale 1ns/100ps
`default_nettype none

module ctrl_reg_slave
    import dma_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  ctrl_addr_t          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  ctrl_word_t          wdata,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  ctrl_addr_t          araddr,
    input  logic                arvalid,
    output logic                arready,
    output ctrl_word_t          rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,

    reg_bus_if.initiator        bus,
    input  ctrl_word_t          rd_data_read,
    input  ctrl_word_t          rd_data_write,
    input  ctrl_word_t          rd_data_count,

    input  logic                read_status_valid,
    input  logic                write_status_valid,
    output logic                dma_enable,
    output logic                dma_irq
);

    logic       wr_accept;
    logic       rd_accept;
    ctrl_word_t enable_word;
    ctrl_word_t rd_merge;

    // one access of each kind in flight
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;

    // word aligned onto the bus
    assign bus.wr_en   = wr_accept;
    assign bus.wr_addr = {awaddr[15:2], 2'b00};
    assign bus.wr_data = wdata;
    assign bus.rd_en   = rd_accept;
    assign bus.rd_addr = {araddr[15:2], 2'b00};

    assign enable_word = (bus.rd_addr == REG_ENABLE) ? ctrl_word_t'(dma_enable) : '0;

    // targets return zero outside their range
    assign rd_merge = enable_word | rd_data_read | rd_data_write | rd_data_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            dma_enable <= 1'b0;
        end else begin
            awready <= wr_accept;
            wready  <= wr_accept;
            arready <= rd_accept;

            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_accept && bus.wr_addr == REG_ENABLE) begin
                dma_enable <= wdata[0];
            end
        end
    end

    // held until the next accepted read
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_merge;
        end
    end

    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    assign dma_irq = read_status_valid || write_status_valid;

endmodule

`default_nettype wire

// ==== logic/dma_desc_channel.sv ====
// ====================
// descriptor channel
// stages one descriptor, launches it and pops completion status
// ====================
`timescale 1ns/100ps
`default_nettype none

module dma_desc_channel
    import dma_ctrl_pkg::*;
#(
    parameter ctrl_addr_t BASE_ADDR = 16'h0100
) (
    input  logic        clk,
    input  logic        rst,

    reg_bus_if.target   bus,
    output ctrl_word_t  rd_data,

    output dma_desc_t   desc,
    output logic        desc_valid,
    input  logic        desc_ready,

    input  dma_tag_t    status_tag,
    input  logic        status_valid,
    output logic        status_ready
);

    pcie_addr_t pcie_addr_q;
    axi_addr_t  axi_addr_q;
    dma_len_t   len_q;
    logic       slot_free;
    logic       launch;
    logic       status_sel;

    // output slot free once the engine takes the current one
    assign slot_free = !desc_valid || desc_ready;

    // a tag write while the slot is still pending is dropped
    assign launch = bus.wr_en && (bus.wr_addr == BASE_ADDR + REG_TAG) && slot_free;

    assign status_sel = (bus.rd_addr == BASE_ADDR + REG_STATUS);

    // staging fields
    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            case (bus.wr_addr)
                BASE_ADDR + REG_PCIE_LO:  pcie_addr_q[31:0]  <= bus.wr_data;
                BASE_ADDR + REG_PCIE_HI:  pcie_addr_q[63:32] <= bus.wr_data;
                BASE_ADDR + REG_AXI_ADDR: axi_addr_q         <= bus.wr_data;
                BASE_ADDR + REG_LEN:      len_q              <= dma_len_t'(bus.wr_data);
                default: ;
            endcase
        end
    end

    // descriptor frozen while valid is up
    always_ff @(posedge clk) begin
        if (launch) begin
            desc <= '{
                pcie_addr: pcie_addr_q,
                axi_addr:  axi_addr_q,
                len:       len_q,
                tag:       dma_tag_t'(bus.wr_data)
            };
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid   <= 1'b0;
            status_ready <= 1'b0;
        end else begin
            if (launch) begin
                desc_valid <= 1'b1;
            end else if (desc_ready) begin
                desc_valid <= 1'b0;
            end

            // pop acknowledge, one cycle after the read
            status_ready <= bus.rd_en && status_sel && status_valid;
        end
    end

    // tag in the low byte, pending flag on top
    always_comb begin
        rd_data = '0;
        if (status_sel) begin
            rd_data = ctrl_word_t'(status_tag);
            rd_data[STATUS_VALID_BIT] = status_valid;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlp_counter_bank.sv ====
// ====================
// TLP counter bank
// packet counts on the rq, rc, cq and cc streams
// ====================
`timescale 1ns/100ps
`default_nettype none

module tlp_counter_bank
    import dma_ctrl_pkg::*;
#(
    parameter ctrl_addr_t BASE_ADDR = 16'h0400
) (
    input  logic        clk,
    input  logic        rst,

    reg_bus_if.target   bus,
    output ctrl_word_t  rd_data,

    // index 0..3 is rq, rc, cq, cc
    input  logic [3:0]  beat_valid,
    input  logic [3:0]  beat_ready,
    input  logic [3:0]  beat_last
);

    ctrl_word_t count [4];

    // one count per completed packet
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (beat_valid[i] && beat_ready[i] && beat_last[i]) begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (bus.rd_addr)
            BASE_ADDR + CNT_RQ: rd_data = count[0];
            BASE_ADDR + CNT_RC: rd_data = count[1];
            BASE_ADDR + CNT_CQ: rd_data = count[2];
            BASE_ADDR + CNT_CC: rd_data = count[3];
            default:            rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/dma_ctrl_top.sv ====
// ====================
// DMA control top
// register slave, two descriptor channels and TLP counters
// ====================
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl_top
    import dma_ctrl_pkg::*;
#(
    parameter ctrl_addr_t READ_BASE  = 16'h0100,
    parameter ctrl_addr_t WRITE_BASE = 16'h0200,
    parameter ctrl_addr_t COUNT_BASE = 16'h0400
) (
    input  logic        clk,
    input  logic        rst,

    // AXI-lite slave
    input  ctrl_addr_t  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  ctrl_word_t  wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  ctrl_addr_t  araddr,
    input  logic        arvalid,
    output logic        arready,
    output ctrl_word_t  rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    output pcie_addr_t  read_desc_pcie_addr,
    output axi_addr_t   read_desc_axi_addr,
    output dma_len_t    read_desc_len,
    output dma_tag_t    read_desc_tag,
    output logic        read_desc_valid,
    input  logic        read_desc_ready,

    output pcie_addr_t  write_desc_pcie_addr,
    output axi_addr_t   write_desc_axi_addr,
    output dma_len_t    write_desc_len,
    output dma_tag_t    write_desc_tag,
    output logic        write_desc_valid,
    input  logic        write_desc_ready,

    input  dma_tag_t    read_status_tag,
    input  logic        read_status_valid,
    output logic        read_status_ready,
    input  dma_tag_t    write_status_tag,
    input  logic        write_status_valid,
    output logic        write_status_ready,

    // observed PCIe streams
    input  logic        rq_valid,
    input  logic        rq_ready,
    input  logic        rq_last,
    input  logic        rc_valid,
    input  logic        rc_ready,
    input  logic        rc_last,
    input  logic        cq_valid,
    input  logic        cq_ready,
    input  logic        cq_last,
    input  logic        cc_valid,
    input  logic        cc_ready,
    input  logic        cc_last,

    output logic        dma_enable,
    output logic        dma_irq
);

    reg_bus_if bus ();

    ctrl_word_t rd_data_read;
    ctrl_word_t rd_data_write;
    ctrl_word_t rd_data_count;
    dma_desc_t  read_desc;
    dma_desc_t  write_desc;

    ctrl_reg_slave i_slave (
        .clk                (clk),
        .rst                (rst),
        .awaddr             (awaddr),
        .awvalid            (awvalid),
        .awready            (awready),
        .wdata              (wdata),
        .wvalid             (wvalid),
        .wready             (wready),
        .bresp              (bresp),
        .bvalid             (bvalid),
        .bready             (bready),
        .araddr             (araddr),
        .arvalid            (arvalid),
        .arready            (arready),
        .rdata              (rdata),
        .rresp              (rresp),
        .rvalid             (rvalid),
        .rready             (rready),
        .bus                (bus.initiator),
        .rd_data_read       (rd_data_read),
        .rd_data_write      (rd_data_write),
        .rd_data_count      (rd_data_count),
        .read_status_valid  (read_status_valid),
        .write_status_valid (write_status_valid),
        .dma_enable         (dma_enable),
        .dma_irq            (dma_irq)
    );

    dma_desc_channel #(
        .BASE_ADDR (READ_BASE)
    ) read_chan (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus.target),
        .rd_data      (rd_data_read),
        .desc         (read_desc),
        .desc_valid   (read_desc_valid),
        .desc_ready   (read_desc_ready),
        .status_tag   (read_status_tag),
        .status_valid (read_status_valid),
        .status_ready (read_status_ready)
    );

    dma_desc_channel #(
        .BASE_ADDR (WRITE_BASE)
    ) write_chan (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus.target),
        .rd_data      (rd_data_write),
        .desc         (write_desc),
        .desc_valid   (write_desc_valid),
        .desc_ready   (write_desc_ready),
        .status_tag   (write_status_tag),
        .status_valid (write_status_valid),
        .status_ready (write_status_ready)
    );

    tlp_counter_bank #(
        .BASE_ADDR (COUNT_BASE)
    ) i_counters (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus.target),
        .rd_data    (rd_data_count),
        .beat_valid ({cc_valid, cq_valid, rc_valid, rq_valid}),
        .beat_ready ({cc_ready, cq_ready, rc_ready, rq_ready}),
        .beat_last  ({cc_last, cq_last, rc_last, rq_last})
    );

    assign read_desc_pcie_addr  = read_desc.pcie_addr;
    assign read_desc_axi_addr   = read_desc.axi_addr;
    assign read_desc_len        = read_desc.len;
    assign read_desc_tag        = read_desc.tag;

    assign write_desc_pcie_addr = write_desc.pcie_addr;
    assign write_desc_axi_addr  = write_desc.axi_addr;
    assign write_desc_len       = write_desc.len;
    assign write_desc_tag       = write_desc.tag;

endmodule

`default_nettype wire

// ==== dv/dma_ctrl_assertions.sv ====
// ====================
// handshake assertions for the DMA control top
// ====================
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl_assertions
    import dma_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      bvalid,
    input  logic      bready,
    input  dma_desc_t read_desc,
    input  logic      read_desc_valid,
    input  logic      read_desc_ready,
    input  dma_desc_t write_desc,
    input  logic      write_desc_valid,
    input  logic      write_desc_ready,
    input  logic      read_status_valid,
    input  logic      read_status_ready,
    input  logic      write_status_valid,
    input  logic      write_status_ready
);

    int failures = 0;

    // write response waits for the master
    bvalid_holds: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            failures++;
            $error("bvalid dropped before bready");
        end

    read_desc_holds: assert property (@(posedge clk) disable iff (rst)
        read_desc_valid && !read_desc_ready |=> read_desc_valid && $stable(read_desc))
        else begin
            failures++;
            $error("read descriptor changed before ready");
        end

    write_desc_holds: assert property (@(posedge clk) disable iff (rst)
        write_desc_valid && !write_desc_ready |=> write_desc_valid && $stable(write_desc))
        else begin
            failures++;
            $error("write descriptor changed before ready");
        end

    // pop only acknowledges pending status
    read_pop_valid: assert property (@(posedge clk) disable iff (rst)
        read_status_ready |-> read_status_valid)
        else begin
            failures++;
            $error("read status_ready without pending status");
        end

    write_pop_valid: assert property (@(posedge clk) disable iff (rst)
        write_status_ready |-> write_status_valid)
        else begin
            failures++;
            $error("write status_ready without pending status");
        end

endmodule

`default_nettype wire

// ==== dv/tb_dma_ctrl.sv ====
// ====================
// testbench for the DMA control top
// replays register operations from a data file
// ====================
`timescale 1ns/100ps
`default_nettype none

module tb_dma_ctrl
    import dma_ctrl_pkg::*;
();

    localparam ctrl_addr_t READ_BASE  = 16'h0100;
    localparam ctrl_addr_t WRITE_BASE = 16'h0200;
    localparam ctrl_addr_t COUNT_BASE = 16'h0400;
    localparam int         WAIT_LIMIT = 1000;

    logic       clk;
    logic       rst;
    ctrl_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    ctrl_word_t wdata;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    ctrl_addr_t araddr;
    logic       arvalid;
    logic       arready;
    ctrl_word_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    pcie_addr_t read_desc_pcie_addr;
    axi_addr_t  read_desc_axi_addr;
    dma_len_t   read_desc_len;
    dma_tag_t   read_desc_tag;
    logic       read_desc_valid;
    logic       read_desc_ready;
    pcie_addr_t write_desc_pcie_addr;
    axi_addr_t  write_desc_axi_addr;
    dma_len_t   write_desc_len;
    dma_tag_t   write_desc_tag;
    logic       write_desc_valid;
    logic       write_desc_ready;
    dma_tag_t   read_status_tag;
    logic       read_status_valid;
    logic       read_status_ready;
    dma_tag_t   write_status_tag;
    logic       write_status_valid;
    logic       write_status_ready;
    logic       rq_valid;
    logic       rq_ready;
    logic       rq_last;
    logic       rc_valid;
    logic       rc_ready;
    logic       rc_last;
    logic       cq_valid;
    logic       cq_ready;
    logic       cq_last;
    logic       cc_valid;
    logic       cc_ready;
    logic       cc_last;
    logic       dma_enable;
    logic       dma_irq;

    // streams by index rq, rc, cq, cc
    logic [3:0] s_valid;
    logic [3:0] s_ready;
    logic [3:0] s_last;
    ctrl_word_t expected_count [4];
    int         pops [2];
    logic [31:0] lfsr;

    assign {cc_valid, cq_valid, rc_valid, rq_valid} = s_valid;
    assign {cc_ready, cq_ready, rc_ready, rq_ready} = s_ready;
    assign {cc_last, cq_last, rc_last, rq_last}     = s_last;

    dma_ctrl_top #(
        .READ_BASE  (READ_BASE),
        .WRITE_BASE (WRITE_BASE),
        .COUNT_BASE (COUNT_BASE)
    ) i_dut (.*);

    bind dma_ctrl_top dma_ctrl_assertions i_assertions (
        .clk                (clk),
        .rst                (rst),
        .bvalid             (bvalid),
        .bready             (bready),
        .read_desc          (read_desc),
        .read_desc_valid    (read_desc_valid),
        .read_desc_ready    (read_desc_ready),
        .write_desc         (write_desc),
        .write_desc_valid   (write_desc_valid),
        .write_desc_ready   (write_desc_ready),
        .read_status_valid  (read_status_valid),
        .read_status_ready  (read_status_ready),
        .write_status_valid (write_status_valid),
        .write_status_ready (write_status_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // pop pulses counted away from the edges
    always @(negedge clk) begin
        if (read_status_ready) pops[0]++;
        if (write_status_ready) pops[1]++;
    end

    always @(negedge clk) begin
        if (i_dut.i_assertions.failures != 0) begin
            $display("A handshake assertion failed at %0t ns", $time);
            stop_failed();
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic ctrl_addr_t counter_offset(input int idx);
        case (idx)
            0:       return CNT_RQ;
            1:       return CNT_RC;
            2:       return CNT_CQ;
            default: return CNT_CC;
        endcase
    endfunction

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        stop_failed();
    endtask

    task automatic check_word(input ctrl_word_t got, input ctrl_word_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_desc(input dma_desc_t got, input dma_desc_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic axi_write(input ctrl_addr_t addr, input ctrl_word_t data);
        int   waited;
        logic done;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) report_timeout("awready after a write request");
        end while (!awready);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_bit(wready, 1'b1, "wready with awready");
        check_bit(bvalid, 1'b1, "bvalid after accept");
        check_word(ctrl_word_t'(bresp), '0, "bresp");
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            bready = random_bit();
            done   = bready;
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) report_timeout("the write response handshake");
        end
        bready = 1'b0;
        check_bit(bvalid, 1'b0, "bvalid after bready");
    endtask

    task automatic axi_read(input ctrl_addr_t addr, output ctrl_word_t data);
        int   waited;
        logic done;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) report_timeout("arready after a read request");
        end while (!arready);
        arvalid = 1'b0;
        check_bit(rvalid, 1'b1, "rvalid with arready");
        check_word(ctrl_word_t'(rresp), '0, "rresp");
        data   = rdata;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            rready = random_bit();
            done   = rready;
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) report_timeout("the read data handshake");
        end
        rready = 1'b0;
        check_bit(rvalid, 1'b0, "rvalid after rready");
    endtask

    // descriptor must hold through random ready stalls
    task automatic run_desc(input int chan, input dma_desc_t exp);
        dma_desc_t got;
        logic      took;
        int        waited;
        took   = 1'b0;
        waited = 0;
        while (!took) begin
            if (chan == 0) begin
                got = {read_desc_pcie_addr, read_desc_axi_addr, read_desc_len, read_desc_tag};
                check_bit(read_desc_valid, 1'b1, "read descriptor valid");
                check_bit(write_desc_valid, 1'b0, "idle write descriptor valid");
            end else begin
                got = {write_desc_pcie_addr, write_desc_axi_addr, write_desc_len,
                       write_desc_tag};
                check_bit(write_desc_valid, 1'b1, "write descriptor valid");
                check_bit(read_desc_valid, 1'b0, "idle read descriptor valid");
            end
            check_desc(got, exp, "descriptor fields");
            took = random_bit();
            if (chan == 0) read_desc_ready = took;
            else write_desc_ready = took;
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) report_timeout("the descriptor handshake");
        end
        read_desc_ready  = 1'b0;
        write_desc_ready = 1'b0;
        check_bit(read_desc_valid, 1'b0, "read descriptor valid after ready");
        check_bit(write_desc_valid, 1'b0, "write descriptor valid after ready");
    endtask

    task automatic run_status(input int chan, input dma_tag_t tag);
        ctrl_addr_t addr;
        ctrl_word_t got;
        ctrl_word_t exp;
        addr = (chan == 0) ? READ_BASE + REG_STATUS : WRITE_BASE + REG_STATUS;
        exp  = ctrl_word_t'(tag);
        exp[STATUS_VALID_BIT] = 1'b1;
        if (chan == 0) begin
            read_status_tag   = tag;
            read_status_valid = 1'b1;
        end else begin
            write_status_tag   = tag;
            write_status_valid = 1'b1;
        end
        pops[chan] = 0;
        @(posedge clk);
        #1;
        check_bit(dma_irq, 1'b1, "dma_irq with pending status");
        axi_read(addr, got);
        check_word(got, exp, "status read");
        check_word(ctrl_word_t'(pops[chan]), 1, "status_ready pulses");
        read_status_tag    = '0;
        read_status_valid  = 1'b0;
        write_status_tag   = '0;
        write_status_valid = 1'b0;
        @(posedge clk);
        #1;
        check_bit(dma_irq, 1'b0, "dma_irq after status drop");
        axi_read(addr, got);
        check_word(got, '0, "status read when idle");
        check_word(ctrl_word_t'(pops[chan]), 1, "status_ready pulses when idle");
    endtask

    // a packet ends on a beat with valid, ready and last
    task automatic run_beats(input int idx, input int beats);
        logic       v;
        logic       r;
        logic       l;
        ctrl_word_t got;
        for (int i = 0; i < beats; i++) begin
            v = random_bit();
            r = random_bit();
            l = random_bit();
            s_valid[idx] = v;
            s_ready[idx] = r;
            s_last[idx]  = l;
            if (v && r && l) expected_count[idx]++;
            @(posedge clk);
            #1;
        end
        s_valid = '0;
        s_ready = '0;
        s_last  = '0;
        axi_read(COUNT_BASE + counter_offset(idx), got);
        check_word(got, expected_count[idx], "packet count");
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != -1 && c != 10) c = $fgetc(fd);
    endtask

    task automatic malformed(input logic [7:0] op);
        $display("Malformed line in the stimulus file for operation %c", op);
        stop_failed();
    endtask

    initial begin
        int          fd;
        int          n;
        logic [7:0]  op;
        logic [63:0] f1;
        logic [63:0] f2;
        logic [63:0] f3;
        logic [63:0] f4;
        logic [63:0] f5;
        ctrl_word_t  got;
        dma_desc_t   exp_desc;

        lfsr = 32'd71440;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        read_desc_ready = 1'b0;
        write_desc_ready = 1'b0;
        read_status_tag = '0;
        read_status_valid = 1'b0;
        write_status_tag = '0;
        write_status_valid = 1'b0;
        s_valid = '0;
        s_ready = '0;
        s_last = '0;
        pops[0] = 0;
        pops[1] = 0;
        for (int i = 0; i < 4; i++) expected_count[i] = '0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit(awready, 1'b0, "awready after reset");
        check_bit(wready, 1'b0, "wready after reset");
        check_bit(bvalid, 1'b0, "bvalid after reset");
        check_bit(arready, 1'b0, "arready after reset");
        check_bit(rvalid, 1'b0, "rvalid after reset");
        check_bit(read_desc_valid, 1'b0, "read descriptor valid after reset");
        check_bit(write_desc_valid, 1'b0, "write descriptor valid after reset");
        check_bit(read_status_ready, 1'b0, "read status_ready after reset");
        check_bit(write_status_ready, 1'b0, "write status_ready after reset");
        check_bit(dma_enable, 1'b0, "dma_enable after reset");

        fd = $fopen("dv/dma_ctrl_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/dma_ctrl_input.txt");
            stop_failed();
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": skip_line(fd);
                "W": begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    if (n != 2) malformed(op);
                    axi_write(ctrl_addr_t'(f1), ctrl_word_t'(f2));
                    if (ctrl_addr_t'(f1) == REG_ENABLE) begin
                        check_bit(dma_enable, f2[0], "dma_enable");
                    end
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    if (n != 2) malformed(op);
                    axi_read(ctrl_addr_t'(f1), got);
                    check_word(got, ctrl_word_t'(f2), "read data");
                end
                "D": begin
                    n = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
                    if (n != 5) malformed(op);
                    exp_desc.pcie_addr = f2;
                    exp_desc.axi_addr  = axi_addr_t'(f3);
                    exp_desc.len       = dma_len_t'(f4);
                    exp_desc.tag       = dma_tag_t'(f5);
                    run_desc(int'(f1), exp_desc);
                end
                "S": begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    if (n != 2) malformed(op);
                    run_status(int'(f1), dma_tag_t'(f2));
                end
                "B": begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    if (n != 2) malformed(op);
                    run_beats(int'(f1), int'(f2));
                end
                default: begin
                    $display("Unknown operation %c in the stimulus file", op);
                    stop_failed();
                end
            endcase
        end
        $fclose(fd);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/dma_ctrl_pkg.sv
logic/reg_bus_if.sv
logic/ctrl_reg_slave.sv
logic/dma_desc_channel.sv
logic/tlp_counter_bank.sv
logic/dma_ctrl_top.sv
dv/dma_ctrl_assertions.sv
dv/tb_dma_ctrl.sv

// ==== Bender.yml ====
package:
  name: dma_ctrl

sources:
  - files:
      - logic/dma_ctrl_pkg.sv
      - logic/reg_bus_if.sv
      - logic/ctrl_reg_slave.sv
      - logic/dma_desc_channel.sv
      - logic/tlp_counter_bank.sv
      - logic/dma_ctrl_top.sv
  - target: test
    files:
      - dv/dma_ctrl_assertions.sv
      - dv/tb_dma_ctrl.sv

// ==== dv/dma_ctrl_input.txt ====
# hex fields: W addr data | R addr expected | D chan pcie_addr axi_addr len tag
# S chan tag | B stream beats  (chan 0 read, 1 write; stream 0 rq, 1 rc, 2 cq, 3 cc)
W 0000 00000001
R 0000 00000001
W 0000 00000000
R 0000 00000000
R 0080 00000000
W 0100 89abcdef
W 0104 01234567
W 0108 10002000
W 0110 00000400
W 0114 0000005a
D 0 0123456789abcdef 10002000 0400 5a
W 0200 76543210
W 0204 fedcba98
W 0208 30004000
W 0210 00001000
W 0214 000000a5
D 1 fedcba9876543210 30004000 1000 a5
S 0 3c
S 1 c3
B 0 40
B 1 25
B 2 33
B 3 18
